// ==== rtl/rob_pkg.sv ====
package rob_pkg;

    localparam int ROB_IDX_W = 4;
    localparam int ROB_DEPTH = 1 << ROB_IDX_W;  // 16 entries
    localparam int LREG_W    = 5;
    localparam int PREG_W    = 6;

    // entry index with the wrap flag on top
    typedef logic [ROB_IDX_W:0] rob_id_t;

    typedef struct packed {
        logic [LREG_W-1:0] lrd;
        logic [PREG_W-1:0] prd;
        logic [PREG_W-1:0] old_prd;     // freed when this entry commits
        logic              need_to_wb;
    } rob_payload_t;

    typedef struct packed {
        logic    valid;
        rob_id_t robid;
    } rob_wb_t;

    typedef struct packed {
        rob_payload_t payload;
        rob_id_t      robid;  // lets the store queue wake up
        logic         valid;
    } rob_commit_t;

    // one lane of the rename map rebuild
    typedef struct packed {
        logic              valid;
        logic [LREG_W-1:0] lrd;
        logic [PREG_W-1:0] prd;
        logic              complete;
    } rob_walk_t;

    typedef enum logic [1:0] {
        ROB_IDLE     = 2'd0,
        ROB_ROLLBACK = 2'd1,
        ROB_WALK     = 2'd2
    } rob_state_e;

endpackage

// ==== rtl/rob_alloc.sv ====
module rob_alloc (
    input  logic                          clock,
    input  logic                          reset_n,
    input  logic [1:0]                    enq_valid,
    input  rob_pkg::rob_state_e           state,
    input  rob_pkg::rob_id_t              flush_robid,
    input  logic                          commit_fire,
    output logic                          enq_ready,
    output rob_pkg::rob_id_t              enq_ptr,
    output logic [rob_pkg::ROB_DEPTH-1:0] enq_we,
    output logic [rob_pkg::ROB_IDX_W:0]   rob_count
);

    localparam int IW = rob_pkg::ROB_IDX_W;

    rob_pkg::rob_id_t head_ptr;     // own copy of the dequeue pointer
    rob_pkg::rob_id_t rollback_next;
    logic             acc0;
    logic             acc1;
    logic [1:0]       enq_num;
    logic [IW-1:0]    slot1_idx;

    // both slots must always fit, so two free entries are needed
    assign enq_ready = (state == rob_pkg::ROB_IDLE) &&
                       (rob_count <= (IW+1)'(rob_pkg::ROB_DEPTH - 2));

    assign acc0    = enq_ready & enq_valid[0];
    assign acc1    = enq_ready & enq_valid[0] & enq_valid[1];  // slot 1 rides with slot 0
    assign enq_num = {1'b0, acc0} + {1'b0, acc1};

    assign slot1_idx     = enq_ptr[IW-1:0] + IW'(1);
    assign rollback_next = flush_robid + rob_pkg::rob_id_t'(1);  // flushing instr survives

    // one-hot write enables at the pointer and the slot after it
    always_comb begin
        for (int i = 0; i < rob_pkg::ROB_DEPTH; i++) begin
            enq_we[i] = (acc0 && (enq_ptr[IW-1:0] == IW'(i))) ||
                        (acc1 && (slot1_idx == IW'(i)));
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            enq_ptr   <= '0;
            head_ptr  <= '0;
            rob_count <= '0;
        end else if (state == rob_pkg::ROB_ROLLBACK) begin
            enq_ptr   <= rollback_next;
            // commit is held here, so the head is stable
            rob_count <= rollback_next - head_ptr;
        end else begin
            enq_ptr   <= enq_ptr + rob_pkg::rob_id_t'(enq_num);
            head_ptr  <= head_ptr + rob_pkg::rob_id_t'(commit_fire);
            rob_count <= rob_count + (IW+1)'(enq_num) - (IW+1)'(commit_fire);
        end
    end

endmodule

// ==== rtl/rob_entry_array.sv ====
module rob_entry_array (
    input  logic                                          clock,
    input  logic                                          reset_n,
    input  logic [rob_pkg::ROB_DEPTH-1:0]                 enq_we,
    input  rob_pkg::rob_payload_t [1:0]                   enq_data,
    input  rob_pkg::rob_id_t                              enq_ptr,
    input  rob_pkg::rob_wb_t                              wb0,
    input  rob_pkg::rob_wb_t                              wb1,
    input  logic                                          commit_fire,
    input  rob_pkg::rob_id_t                              deq_ptr,
    input  logic [rob_pkg::ROB_DEPTH-1:0]                 flush_kill,
    output logic [rob_pkg::ROB_DEPTH-1:0]                 entry_valid,
    output logic [rob_pkg::ROB_DEPTH-1:0]                 entry_complete,
    output rob_pkg::rob_payload_t [rob_pkg::ROB_DEPTH-1:0] entry_data
);

    localparam int IW = rob_pkg::ROB_IDX_W;

    logic [rob_pkg::ROB_DEPTH-1:0] wb_hit;
    logic [rob_pkg::ROB_DEPTH-1:0] retire_hit;

    // index match is enough, a live id is unique in its slot
    always_comb begin
        for (int i = 0; i < rob_pkg::ROB_DEPTH; i++) begin
            wb_hit[i] = (wb0.valid && (wb0.robid[IW-1:0] == IW'(i))) ||
                        (wb1.valid && (wb1.robid[IW-1:0] == IW'(i)));
            retire_hit[i] = commit_fire && (deq_ptr[IW-1:0] == IW'(i));
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            entry_valid    <= '0;
            entry_complete <= '0;
        end else begin
            for (int i = 0; i < rob_pkg::ROB_DEPTH; i++) begin
                if (enq_we[i]) begin
                    entry_valid[i]    <= 1'b1;
                    entry_complete[i] <= 1'b0;  // fresh entry waits for writeback
                end else begin
                    if (retire_hit[i] || flush_kill[i]) begin
                        entry_valid[i] <= 1'b0;
                    end
                    if (wb_hit[i]) begin
                        entry_complete[i] <= 1'b1;
                    end
                end
            end
        end
    end

    // slot 0 lands at the pointer, slot 1 just after it
    always_ff @(posedge clock) begin
        for (int i = 0; i < rob_pkg::ROB_DEPTH; i++) begin
            if (enq_we[i]) begin
                entry_data[i] <= (enq_ptr[IW-1:0] == IW'(i)) ? enq_data[0] : enq_data[1];
            end
        end
    end

endmodule

// ==== rtl/rob_retire.sv ====
module rob_retire (
    input  logic                                          clock,
    input  logic                                          reset_n,
    input  rob_pkg::rob_state_e                           state,
    input  logic [rob_pkg::ROB_DEPTH-1:0]                 entry_valid,
    input  logic [rob_pkg::ROB_DEPTH-1:0]                 entry_complete,
    input  rob_pkg::rob_payload_t [rob_pkg::ROB_DEPTH-1:0] entry_data,
    output rob_pkg::rob_commit_t                          commit,
    output logic                                          commit_fire,
    output rob_pkg::rob_id_t                              deq_ptr
);

    localparam int IW = rob_pkg::ROB_IDX_W;

    logic [IW-1:0] head;

    assign head = deq_ptr[IW-1:0];

    // no back-pressure, a shown commit is taken at the next edge
    assign commit_fire = (state == rob_pkg::ROB_IDLE) &&
                         entry_valid[head] && entry_complete[head];

    always_comb begin
        commit.payload = entry_data[head];
        commit.robid   = deq_ptr;
        commit.valid   = commit_fire;
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            deq_ptr <= '0;
        end else begin
            deq_ptr <= deq_ptr + rob_pkg::rob_id_t'(commit_fire);  // one per cycle
        end
    end

endmodule

// ==== rtl/rob_recovery.sv ====
module rob_recovery (
    input  logic                                          clock,
    input  logic                                          reset_n,
    input  logic                                          flush_valid,
    input  rob_pkg::rob_id_t                              flush_robid,
    input  rob_pkg::rob_id_t                              enq_ptr,
    input  rob_pkg::rob_id_t                              deq_ptr,
    input  logic [rob_pkg::ROB_DEPTH-1:0]                 entry_valid,
    input  logic [rob_pkg::ROB_DEPTH-1:0]                 entry_complete,
    input  rob_pkg::rob_payload_t [rob_pkg::ROB_DEPTH-1:0] entry_data,
    output rob_pkg::rob_state_e                           state,
    output logic [rob_pkg::ROB_DEPTH-1:0]                 flush_kill,
    output rob_pkg::rob_id_t                              rollback_robid,
    output rob_pkg::rob_walk_t                            walk0,
    output rob_pkg::rob_walk_t                            walk1
);

    localparam int IW = rob_pkg::ROB_IDX_W;

    rob_pkg::rob_state_e next_state;
    rob_pkg::rob_id_t    walk_ptr;
    rob_pkg::rob_id_t    walk_left;   // entries still to walk before enq_ptr
    rob_pkg::rob_id_t    kill_span;   // entries younger than the flushing one
    logic [IW-1:0]       lane0_idx;
    logic [IW-1:0]       lane1_idx;
    logic                walking;

    function automatic rob_pkg::rob_walk_t walk_lane(
        input logic                  in_range,
        input logic                  valid,
        input logic                  complete,
        input rob_pkg::rob_payload_t data
    );
        rob_pkg::rob_walk_t lane;
        lane.valid    = in_range && valid && data.need_to_wb;
        lane.lrd      = data.lrd;
        lane.prd      = data.prd;
        lane.complete = complete;
        return lane;
    endfunction

    // a new flush always restarts the rollback
    always_comb begin
        next_state = state;
        if (flush_valid) begin
            next_state = rob_pkg::ROB_ROLLBACK;
        end else begin
            case (state)
                rob_pkg::ROB_ROLLBACK: next_state = rob_pkg::ROB_WALK;
                rob_pkg::ROB_WALK: begin
                    if (walk_left <= rob_pkg::rob_id_t'(2)) begin
                        next_state = rob_pkg::ROB_IDLE;  // last pair this cycle
                    end
                end
                rob_pkg::ROB_IDLE: next_state = rob_pkg::ROB_IDLE;
                default: next_state = rob_pkg::ROB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state    <= rob_pkg::ROB_IDLE;
            walk_ptr <= '0;
        end else begin
            state <= next_state;
            if (state == rob_pkg::ROB_ROLLBACK) begin
                walk_ptr <= deq_ptr;  // rebuild starts at the head
            end else if (walking) begin
                walk_ptr <= walk_ptr + rob_pkg::rob_id_t'(2);
            end
        end
    end

    // flush id is a pulse, hold it for the rollback cycle
    always_ff @(posedge clock) begin
        if (flush_valid) begin
            rollback_robid <= flush_robid;
        end
    end

    // age test: offset past the flushing entry against the younger span
    assign kill_span = enq_ptr - rollback_robid - rob_pkg::rob_id_t'(1);

    always_comb begin
        for (int i = 0; i < rob_pkg::ROB_DEPTH; i++) begin
            flush_kill[i] = (state == rob_pkg::ROB_ROLLBACK) &&
                ({1'b0, IW'(i) - rollback_robid[IW-1:0] - IW'(1)} < kill_span);
        end
    end

    assign walking   = (state == rob_pkg::ROB_WALK);
    assign walk_left = enq_ptr - walk_ptr;
    assign lane0_idx = walk_ptr[IW-1:0];
    assign lane1_idx = lane0_idx + IW'(1);

    assign walk0 = walk_lane(walking && (walk_left != '0), entry_valid[lane0_idx],
                             entry_complete[lane0_idx], entry_data[lane0_idx]);
    assign walk1 = walk_lane(walking && (walk_left > rob_pkg::rob_id_t'(1)),
                             entry_valid[lane1_idx], entry_complete[lane1_idx],
                             entry_data[lane1_idx]);

endmodule

// ==== rtl/rob_top.sv ====
module rob_top (
    input  logic                        clock,
    input  logic                        reset_n,
    input  logic [1:0]                  enq_valid,
    input  rob_pkg::rob_payload_t [1:0] enq_data,
    output logic                        enq_ready,
    output rob_pkg::rob_id_t            enq_robid,
    input  rob_pkg::rob_wb_t            wb0,
    input  rob_pkg::rob_wb_t            wb1,
    input  logic                        flush_valid,
    input  rob_pkg::rob_id_t            flush_robid,
    output rob_pkg::rob_commit_t        commit,
    output rob_pkg::rob_walk_t          walk0,
    output rob_pkg::rob_walk_t          walk1,
    output rob_pkg::rob_state_e         rob_state,
    output logic [rob_pkg::ROB_IDX_W:0] rob_count
);

    logic [rob_pkg::ROB_DEPTH-1:0]                  enq_we;
    logic [rob_pkg::ROB_DEPTH-1:0]                  entry_valid;
    logic [rob_pkg::ROB_DEPTH-1:0]                  entry_complete;
    rob_pkg::rob_payload_t [rob_pkg::ROB_DEPTH-1:0] entry_data;
    logic [rob_pkg::ROB_DEPTH-1:0]                  flush_kill;
    logic                                           commit_fire;
    rob_pkg::rob_id_t                               deq_ptr;
    rob_pkg::rob_id_t                               rollback_robid;

    // enq_robid doubles as the internal enqueue pointer
    rob_alloc u_alloc (
        .clock       (clock),
        .reset_n     (reset_n),
        .enq_valid   (enq_valid),
        .state       (rob_state),
        .flush_robid (rollback_robid),  // latched copy from recovery
        .commit_fire (commit_fire),
        .enq_ready   (enq_ready),
        .enq_ptr     (enq_robid),
        .enq_we      (enq_we),
        .rob_count   (rob_count)
    );

    rob_entry_array u_entries (
        .clock          (clock),
        .reset_n        (reset_n),
        .enq_we         (enq_we),
        .enq_data       (enq_data),
        .enq_ptr        (enq_robid),
        .wb0            (wb0),
        .wb1            (wb1),
        .commit_fire    (commit_fire),
        .deq_ptr        (deq_ptr),
        .flush_kill     (flush_kill),
        .entry_valid    (entry_valid),
        .entry_complete (entry_complete),
        .entry_data     (entry_data)
    );

    rob_retire u_retire (
        .clock          (clock),
        .reset_n        (reset_n),
        .state          (rob_state),
        .entry_valid    (entry_valid),
        .entry_complete (entry_complete),
        .entry_data     (entry_data),
        .commit         (commit),
        .commit_fire    (commit_fire),
        .deq_ptr        (deq_ptr)
    );

    rob_recovery u_recovery (
        .clock          (clock),
        .reset_n        (reset_n),
        .flush_valid    (flush_valid),
        .flush_robid    (flush_robid),
        .enq_ptr        (enq_robid),
        .deq_ptr        (deq_ptr),
        .entry_valid    (entry_valid),
        .entry_complete (entry_complete),
        .entry_data     (entry_data),
        .state          (rob_state),
        .flush_kill     (flush_kill),
        .rollback_robid (rollback_robid),
        .walk0          (walk0),
        .walk1          (walk1)
    );

endmodule

// ==== tests/rob_clock_gen.sv ====
module rob_clock_gen (
    output logic clock,
    output logic reset_n
);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;  // 100 unit period
    end

    initial begin
        reset_n = 1'b0;
        repeat (16) @(posedge clock);
        reset_n <= 1'b1;
    end

endmodule

// ==== tests/rob_sva.sv ====
module rob_sva (
    input logic                        clock,
    input logic                        reset_n,
    input rob_pkg::rob_commit_t        commit,
    input rob_pkg::rob_walk_t          walk0,
    input rob_pkg::rob_walk_t          walk1,
    input rob_pkg::rob_state_e         rob_state,
    input logic [rob_pkg::ROB_IDX_W:0] rob_count,
    input logic                        enq_ready
);

    a_commit_idle: assert property (@(posedge clock) disable iff (!reset_n)
        commit.valid |-> rob_state == rob_pkg::ROB_IDLE)
        else $error("commit shown outside idle");

    a_walk_state: assert property (@(posedge clock) disable iff (!reset_n)
        (walk0.valid || walk1.valid) |-> rob_state == rob_pkg::ROB_WALK)
        else $error("walk lane valid outside walk");

    a_count_max: assert property (@(posedge clock) disable iff (!reset_n)
        rob_count <= (rob_pkg::ROB_IDX_W+1)'(rob_pkg::ROB_DEPTH))
        else $error("occupancy above depth");

    a_ready_idle: assert property (@(posedge clock) disable iff (!reset_n)
        rob_state != rob_pkg::ROB_IDLE |-> !enq_ready)
        else $error("enqueue ready outside idle");

endmodule

bind rob_top rob_sva u_sva (
    .clock     (clock),
    .reset_n   (reset_n),
    .commit    (commit),
    .walk0     (walk0),
    .walk1     (walk1),
    .rob_state (rob_state),
    .rob_count (rob_count),
    .enq_ready (enq_ready)
);

// ==== tests/rob_tb.sv ====
module rob_tb;

    localparam int ROWS = 16;

    typedef struct packed {
        logic [1:0] n_enq;
        logic [3:0] n_wb;
        logic       flush;
    } row_t;

    // enqueue slots, writebacks to issue, flush after the row
    row_t stim [ROWS] = '{
        '{2'd2, 4'd0, 1'b0}, '{2'd2, 4'd1, 1'b0}, '{2'd1, 4'd2, 1'b0}, '{2'd2, 4'd0, 1'b0},
        '{2'd2, 4'd0, 1'b0}, '{2'd2, 4'd0, 1'b0}, '{2'd2, 4'd0, 1'b0}, '{2'd2, 4'd0, 1'b0},
        '{2'd2, 4'd0, 1'b0}, '{2'd2, 4'd0, 1'b0}, '{2'd0, 4'd8, 1'b0}, '{2'd2, 4'd3, 1'b1},
        '{2'd2, 4'd4, 1'b0}, '{2'd1, 4'd2, 1'b1}, '{2'd2, 4'd6, 1'b0}, '{2'd2, 4'd8, 1'b1}
    };

    logic                        clock;
    logic                        reset_n;
    logic [1:0]                  enq_valid;
    rob_pkg::rob_payload_t [1:0] enq_data;
    logic                        enq_ready;
    rob_pkg::rob_id_t            enq_robid;
    rob_pkg::rob_wb_t            wb0;
    rob_pkg::rob_wb_t            wb1;
    logic                        flush_valid;
    rob_pkg::rob_id_t            flush_robid;
    rob_pkg::rob_commit_t        commit;
    rob_pkg::rob_walk_t          walk0;
    rob_pkg::rob_walk_t          walk1;
    rob_pkg::rob_state_e         rob_state;
    logic [rob_pkg::ROB_IDX_W:0] rob_count;

    // reference queue with the oldest entry first
    rob_pkg::rob_id_t      q_id[$];
    rob_pkg::rob_payload_t q_pl[$];
    bit                    q_done[$];
    rob_pkg::rob_id_t      next_id;
    logic [11:0]           walk_seen[$];
    int                    errors;
    logic [31:0]           lcg_state;

    rob_clock_gen u_clk (.clock(clock), .reset_n(reset_n));

    rob_top u_dut (
        .clock(clock), .reset_n(reset_n), .enq_valid(enq_valid), .enq_data(enq_data),
        .enq_ready(enq_ready), .enq_robid(enq_robid), .wb0(wb0), .wb1(wb1),
        .flush_valid(flush_valid), .flush_robid(flush_robid), .commit(commit),
        .walk0(walk0), .walk1(walk1), .rob_state(rob_state), .rob_count(rob_count)
    );

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic int pick(input int n);
        return int'(next_rand() >> 8) % n;
    endfunction

    function automatic rob_pkg::rob_payload_t rand_payload();
        logic [31:0] r;
        r = next_rand();
        return r[24:7];
    endfunction

    // true when id was allocated after fid
    function automatic bit younger(input rob_pkg::rob_id_t id, input rob_pkg::rob_id_t fid);
        rob_pkg::rob_id_t d;
        d = id - fid;
        return (d != '0) && (d < rob_pkg::rob_id_t'(rob_pkg::ROB_DEPTH));
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic mark_done(input rob_pkg::rob_wb_t wb);
        for (int i = 0; i < q_id.size(); i++) begin
            if (wb.valid && q_id[i] == wb.robid) begin
                q_done[i] = 1'b1;
            end
        end
    endtask

    // random writeback order over entries still waiting
    task automatic pick_wb(input bit enable, output int issued);
        int cand[$];
        int k;
        issued = 0;
        wb0 <= '0;
        wb1 <= '0;
        for (int i = 0; i < q_id.size(); i++) begin
            if (!q_done[i]) begin
                cand.push_back(i);
            end
        end
        if (enable && cand.size() > 0) begin
            k = pick(cand.size());
            wb0 <= '{1'b1, q_id[cand[k]]};
            cand.delete(k);
            issued = 1;
            if (cand.size() > 0) begin
                k = pick(cand.size());
                wb1 <= '{1'b1, q_id[cand[k]]};
                issued = 2;
            end
        end
    endtask

    task automatic observe();
        bit exp_commit;
        exp_commit = 1'b0;
        if (rob_state == rob_pkg::ROB_IDLE) begin
            check("rob_count", rob_count, q_id.size());
            check("enq_ready", enq_ready, q_id.size() <= rob_pkg::ROB_DEPTH - 2);
            if (q_id.size() > 0) begin
                exp_commit = q_done[0];  // only the head may commit
            end
        end
        check("commit.valid", commit.valid, exp_commit);
        if (commit.valid && exp_commit) begin
            check("commit.robid", commit.robid, q_id[0]);
            check("commit.payload", commit.payload, q_pl[0]);
            void'(q_id.pop_front());
            void'(q_pl.pop_front());
            void'(q_done.pop_front());
        end
        if (rob_state == rob_pkg::ROB_WALK) begin
            if (walk0.valid) begin
                walk_seen.push_back({walk0.lrd, walk0.prd, walk0.complete});
            end
            if (walk1.valid) begin
                walk_seen.push_back({walk1.lrd, walk1.prd, walk1.complete});
            end
        end
        if (enq_valid[0] && enq_ready) begin
            check("enq_robid", enq_robid, next_id);
            for (int s = 0; s < 2; s++) begin
                if (enq_valid[s]) begin
                    q_id.push_back(next_id);
                    q_pl.push_back(enq_data[s]);
                    q_done.push_back(1'b0);
                    next_id = next_id + 1'b1;
                end
            end
        end
        mark_done(wb0);
        mark_done(wb1);
    endtask

    // drive at the rising edge and look at the falling edge
    task automatic step(input bit try_enq, input int n_enq, input bit do_wb, input bit do_flush,
                        input rob_pkg::rob_id_t fid, output int issued);
        @(posedge clock);
        enq_valid   <= !try_enq ? 2'b00 : (n_enq == 2 ? 2'b11 : 2'b01);
        enq_data[0] <= rand_payload();
        enq_data[1] <= rand_payload();
        flush_valid <= do_flush;
        flush_robid <= fid;
        pick_wb(do_wb, issued);
        @(negedge clock);
        observe();
    endtask

    task automatic run_flush();
        rob_pkg::rob_id_t fid;
        logic [11:0]      exp_walk[$];
        int               issued;
        fid = q_id[pick(q_id.size())];
        step(1'b0, 0, 1'b0, 1'b1, fid, issued);
        while (q_id.size() > 0 && younger(q_id[q_id.size()-1], fid)) begin
            void'(q_id.pop_back());
            void'(q_pl.pop_back());
            void'(q_done.pop_back());
        end
        next_id = fid + 1'b1;
        for (int i = 0; i < q_id.size(); i++) begin
            if (q_pl[i].need_to_wb) begin
                exp_walk.push_back({q_pl[i].lrd, q_pl[i].prd, q_done[i]});
            end
        end
        walk_seen.delete();
        // flush id bus moves away once the pulse is over
        step(1'b0, 0, 1'b0, 1'b0, ~fid, issued);
        check("rob_state", rob_state, rob_pkg::ROB_ROLLBACK);
        do begin
            step(1'b0, 0, 1'b0, 1'b0, ~fid, issued);
        end while (rob_state != rob_pkg::ROB_IDLE);
        check("walk length", walk_seen.size(), exp_walk.size());
        for (int i = 0; i < walk_seen.size() && i < exp_walk.size(); i++) begin
            check("walk lane", walk_seen[i], exp_walk[i]);
        end
        check("enq_robid", enq_robid, next_id);
    endtask

    task automatic run_row(input row_t row);
        bit acc;
        int wb_left;
        int issued;
        acc     = (row.n_enq == 0);
        wb_left = row.n_wb;
        while (!acc || wb_left > 0) begin
            step(!acc, row.n_enq, wb_left > 0, 1'b0, '0, issued);
            wb_left = (issued == 0) ? 0 : wb_left - issued;
            if (!acc && (enq_ready || wb_left <= 0)) begin
                acc = 1'b1;  // refused while full with nothing left to free space
            end
        end
        if (row.flush && q_id.size() > 0) begin
            run_flush();
        end
    endtask

    initial begin
        #((ROWS + 2) * 200 * 100);
        $display("timeout: the run did not finish in time");
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        int issued;
        enq_valid   = '0;
        enq_data    = '0;
        wb0         = '0;
        wb1         = '0;
        flush_valid = 1'b0;
        flush_robid = '0;
        next_id     = '0;
        errors      = 0;
        lcg_state   = 32'd80095;
        @(posedge reset_n);
        @(negedge clock);
        check("enq_ready", enq_ready, 1'b1);
        check("commit.valid", commit.valid, 1'b0);
        check("rob_state", rob_state, rob_pkg::ROB_IDLE);
        check("rob_count", rob_count, 0);
        for (int r = 0; r < ROWS; r++) begin
            run_row(stim[r]);
        end
        while (q_id.size() > 0) begin
            step(1'b0, 0, 1'b1, 1'b0, '0, issued);
        end
        $display("checks finished, errors: %0d", errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== reorder_buffer.f ====
rtl/rob_pkg.sv
rtl/rob_alloc.sv
rtl/rob_entry_array.sv
rtl/rob_retire.sv
rtl/rob_recovery.sv
rtl/rob_top.sv
tests/rob_clock_gen.sv
tests/rob_sva.sv
tests/rob_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module rob_tb \
    -f reorder_buffer.f -o rob_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/rob_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with an error"
    exit 1
fi

if echo "$out" | grep -q "^Result: PASSED$"; then
    exit 0
fi
exit 1
